//--- Makefile
TOP := tb_qdr_ctrl

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert --timescale 1ns/100ps -f sim.f \
		--top-module $(TOP) -Mdir obj_dir -o $(TOP)

run: build
	./obj_dir/$(TOP) 2>&1 | tee sim.log
	@if grep -q "Simulation finished: FAIL" sim.log || \
		! grep -q "Simulation finished: PASS" sim.log; then exit 1; fi

lint:
	verilator --lint-only -Wall --timing --timescale 1ns/100ps -f sim.f \
		--top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

//--- sim.f
src/qdr_pkg.sv
src/qdr_req_merge.sv
src/qdr_cmd_fifo.sv
src/qdr_fsm.sv
src/qdr_cmd_issue.sv
src/qdr_ctrl_top.sv
test/qdr_mem_model.sv
test/tb_qdr_ctrl.sv

//--- src/qdr_cmd_fifo.sv
// Show-ahead command queue holding QDR slots between the merger and the issue stage
module qdr_cmd_fifo (
	input  logic               clk,
	input  logic               reset_n,
	input  logic               push,
	input  logic               pop,
	input  qdr_pkg::qdr_slot_t push_slot,
	output qdr_pkg::qdr_slot_t head,
	output logic               empty,
	output logic               full
);

	// Slot storage, contents are only meaningful between the pointers
	qdr_pkg::qdr_slot_t mem [qdr_pkg::FIFO_DEPTH];

	qdr_pkg::fifo_ptr_t wr_ptr;
	qdr_pkg::fifo_ptr_t rd_ptr;
	qdr_pkg::fifo_cnt_t count;

	//////////////////////////////////////////////////
	// Status and head

	assign empty = (count == '0);
	assign full  = (count == qdr_pkg::FIFO_FULL_CNT);

	// The oldest slot is always visible without a read request
	// A slot written at one edge shows up here right after that edge
	assign head = mem[rd_ptr];

	//////////////////////////////////////////////////
	// Storage

	always_ff @(posedge clk)
	begin
		if (push)
			mem[wr_ptr] <= push_slot;
	end

	//////////////////////////////////////////////////
	// Pointers and occupancy

	always_ff @(posedge clk or negedge reset_n)
	begin
		if (!reset_n)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else
		begin
			if (push)
				wr_ptr <= wr_ptr + qdr_pkg::fifo_ptr_t'(1);
			if (pop)
				rd_ptr <= rd_ptr + qdr_pkg::fifo_ptr_t'(1);
			// Simultaneous push and pop leave the count unchanged
			case ({push, pop})
				2'b10:   count <= count + qdr_pkg::fifo_cnt_t'(1);
				2'b01:   count <= count - qdr_pkg::fifo_cnt_t'(1);
				default: count <= count;
			endcase
		end
	end

	// Overflow would overwrite the oldest pending slot
	a_no_push_full: assert property (@(posedge clk) disable iff (!reset_n)
		push |-> !full);

	// Underflow would issue a stale slot to the memory
	a_no_pop_empty: assert property (@(posedge clk) disable iff (!reset_n)
		pop |-> !empty);

endmodule

//--- src/qdr_cmd_issue.sv
// Issue stage that drives registered QDR command pins and returns read data in order
module qdr_cmd_issue (
	input  logic                       clk,
	input  logic                       reset_n,
	input  logic                       do_write,
	input  logic                       do_read,
	input  qdr_pkg::qdr_slot_t         head,
	output logic                       pop,
	output qdr_pkg::qdr_pins_t         mem_cmd,
	input  logic [qdr_pkg::DATA_W-1:0] mem_q,
	output logic                       avl_rdata_valid,
	output logic [qdr_pkg::DATA_W-1:0] avl_rdata
);

	// Pin registers, strobes are control state and the rest is payload
	logic                       cmd_w_n;
	logic                       cmd_r_n;
	logic [qdr_pkg::ADDR_W-1:0] cmd_waddr;
	logic [qdr_pkg::ADDR_W-1:0] cmd_raddr;
	logic [qdr_pkg::DATA_W-1:0] cmd_d;

	// One bit per read in flight, stage 0 is the cycle the memory samples the read
	logic [qdr_pkg::RD_LATENCY:0] rd_track;

	// Every slot the state machine releases is consumed at this edge
	assign pop = do_write | do_read;

	//////////////////////////////////////////////////
	// Command pins

	always_ff @(posedge clk or negedge reset_n)
	begin
		if (!reset_n)
		begin
			cmd_w_n <= 1'b1;
			cmd_r_n <= 1'b1;
		end
		else
		begin
			// Strobes fall back high on any cycle without a command
			cmd_w_n <= ~do_write;
			cmd_r_n <= ~do_read;
		end
	end

	// Address and data buses hold their last value while idle
	always_ff @(posedge clk)
	begin
		if (do_write)
		begin
			cmd_waddr <= head.waddr;
			cmd_d     <= head.wdata;
		end
		if (do_read)
			cmd_raddr <= head.raddr;
	end

	assign mem_cmd = '{
		w_n:   cmd_w_n,
		r_n:   cmd_r_n,
		waddr: cmd_waddr,
		raddr: cmd_raddr,
		d:     cmd_d
	};

	//////////////////////////////////////////////////
	// Read return path

	// The tracker shifts one stage per edge so back-to-back reads overlap
	// When the last stage is set mem_q carries that read's data
	always_ff @(posedge clk or negedge reset_n)
	begin
		if (!reset_n)
		begin
			rd_track        <= '0;
			avl_rdata_valid <= 1'b0;
		end
		else
		begin
			rd_track        <= {rd_track[qdr_pkg::RD_LATENCY-1:0], ~cmd_r_n};
			avl_rdata_valid <= rd_track[qdr_pkg::RD_LATENCY];
		end
	end

	always_ff @(posedge clk)
	begin
		if (rd_track[qdr_pkg::RD_LATENCY])
			avl_rdata <= mem_q;
	end

	// Each read strobe on the pins comes back as exactly one data pulse
	a_read_returns: assert property (@(posedge clk) disable iff (!reset_n)
		!mem_cmd.r_n |-> ##(qdr_pkg::RD_LATENCY + 2) avl_rdata_valid);

endmodule

//--- src/qdr_ctrl_top.sv
// Top level of the QDR II command path from the Avalon port to the memory pins
module qdr_ctrl_top (
	input  logic                       clk,
	input  logic                       reset_n,
	// Avalon request side
	input  logic                       avl_write,
	input  logic [qdr_pkg::ADDR_W-1:0] avl_waddr,
	input  logic [qdr_pkg::DATA_W-1:0] avl_wdata,
	input  logic                       avl_read,
	input  logic [qdr_pkg::ADDR_W-1:0] avl_raddr,
	output logic                       avl_ready,
	output logic                       avl_rdata_valid,
	output logic [qdr_pkg::DATA_W-1:0] avl_rdata,
	// PHY calibration status levels
	input  logic                       init_complete,
	input  logic                       init_fail,
	// Memory side
	output qdr_pkg::qdr_pins_t         mem_cmd,
	input  logic [qdr_pkg::DATA_W-1:0] mem_q
);

	// Merger to queue
	qdr_pkg::qdr_slot_t push_slot;
	logic               push;
	logic               full;

	// Queue to state machine and issue stage
	qdr_pkg::qdr_slot_t head;
	logic               empty;
	logic               pop;
	logic               do_write;
	logic               do_read;

	qdr_req_merge i_merge (
		.clk       (clk),
		.reset_n   (reset_n),
		.avl_write (avl_write),
		.avl_read  (avl_read),
		.avl_waddr (avl_waddr),
		.avl_raddr (avl_raddr),
		.avl_wdata (avl_wdata),
		.full      (full),
		.avl_ready (avl_ready),
		.push      (push),
		.push_slot (push_slot)
	);

	qdr_cmd_fifo i_fifo (
		.clk       (clk),
		.reset_n   (reset_n),
		.push      (push),
		.pop       (pop),
		.push_slot (push_slot),
		.head      (head),
		.empty     (empty),
		.full      (full)
	);

	// The head flags are stale while the queue is empty
	qdr_fsm i_fsm (
		.clk           (clk),
		.reset_n       (reset_n),
		.init_complete (init_complete),
		.init_fail     (init_fail),
		.write_req     (head.write & ~empty),
		.read_req      (head.read & ~empty),
		.do_write      (do_write),
		.do_read       (do_read)
	);

	qdr_cmd_issue i_issue (
		.clk             (clk),
		.reset_n         (reset_n),
		.do_write        (do_write),
		.do_read         (do_read),
		.head            (head),
		.pop             (pop),
		.mem_cmd         (mem_cmd),
		.mem_q           (mem_q),
		.avl_rdata_valid (avl_rdata_valid),
		.avl_rdata       (avl_rdata)
	);

endmodule

//--- src/qdr_fsm.sv
// Calibration state machine that lets queued slots reach the memory only after PHY init
module qdr_fsm (
	input  logic clk,
	input  logic reset_n,
	input  logic init_complete,
	input  logic init_fail,
	input  logic write_req,
	input  logic read_req,
	output logic do_write,
	output logic do_read
);

	qdr_pkg::qdr_state_t state;

	//////////////////////////////////////////////////
	// State register

	always_ff @(posedge clk or negedge reset_n)
	begin
		if (!reset_n)
			state <= qdr_pkg::INIT;
		else
		begin
			case (state)
				qdr_pkg::INIT:
				begin
					// Success wins when both status levels rise together
					if (init_complete)
						state <= qdr_pkg::INIT_COMPLETE;
					else if (init_fail)
						state <= qdr_pkg::INIT_FAIL;
				end
				// Both outcomes are final until the next reset
				qdr_pkg::INIT_FAIL:     state <= qdr_pkg::INIT_FAIL;
				qdr_pkg::INIT_COMPLETE: state <= qdr_pkg::INIT_COMPLETE;
				default:                state <= qdr_pkg::INIT;
			endcase
		end
	end

	//////////////////////////////////////////////////
	// Command gating

	// Requests pass in the same cycle once calibration has succeeded
	always_comb
	begin
		do_write = 1'b0;
		do_read  = 1'b0;
		if (state == qdr_pkg::INIT_COMPLETE)
		begin
			do_write = write_req;
			do_read  = read_req;
		end
	end

	// After a failed calibration nothing is ever issued again
	a_fail_silent: assert property (@(posedge clk) disable iff (!reset_n)
		state == qdr_pkg::INIT_FAIL |=> state == qdr_pkg::INIT_FAIL && !do_write && !do_read);

endmodule

//--- src/qdr_pkg.sv
// QDR II controller package with widths, queue sizing, read latency, slot and pin types
package qdr_pkg;

	//////////////////////////////////////////////////
	// Sizing

	// Memory word address width
	localparam int unsigned ADDR_W = 10;
	// Data width of an x18 part
	localparam int unsigned DATA_W = 18;
	// Number of QDR cycle slots the command queue can hold
	localparam int unsigned FIFO_DEPTH = 8;
	// Pointer width into the queue, depth is a power of two so pointers wrap naturally
	localparam int unsigned FIFO_PTR_W = $clog2(FIFO_DEPTH);
	// Memory cycles from a sampled read strobe to valid data on q
	localparam int unsigned RD_LATENCY = 2;

	typedef logic [FIFO_PTR_W-1:0] fifo_ptr_t;
	typedef logic [FIFO_PTR_W:0] fifo_cnt_t;

	// Occupancy at which the queue reports full
	localparam fifo_cnt_t FIFO_FULL_CNT = fifo_cnt_t'(FIFO_DEPTH);

	//////////////////////////////////////////////////
	// Slot and pin types

	// One QDR cycle with an independent write half and read half
	typedef struct packed {
		logic              write;
		logic [ADDR_W-1:0] waddr;
		logic [DATA_W-1:0] wdata;
		logic              read;
		logic [ADDR_W-1:0] raddr;
	} qdr_slot_t;

	// Command pins toward the memory, strobes are active low and idle high
	typedef struct packed {
		logic              w_n;
		logic              r_n;
		logic [ADDR_W-1:0] waddr;
		logic [ADDR_W-1:0] raddr;
		logic [DATA_W-1:0] d;
	} qdr_pins_t;

	// Calibration state of the controller
	typedef enum logic [1:0] {
		INIT,
		INIT_FAIL,
		INIT_COMPLETE
	} qdr_state_t;

endpackage

//--- src/qdr_req_merge.sv
// Request merger that packs Avalon reads and writes into QDR slots for the command queue
module qdr_req_merge (
	input  logic                       clk,
	input  logic                       reset_n,
	input  logic                       avl_write,
	input  logic                       avl_read,
	input  logic [qdr_pkg::ADDR_W-1:0] avl_waddr,
	input  logic [qdr_pkg::ADDR_W-1:0] avl_raddr,
	input  logic [qdr_pkg::DATA_W-1:0] avl_wdata,
	input  logic                       full,
	output logic                       avl_ready,
	output logic                       push,
	output qdr_pkg::qdr_slot_t         push_slot
);

	qdr_pkg::qdr_slot_t new_slot;
	qdr_pkg::qdr_slot_t hold_slot;
	logic               hold_valid;
	logic               accept;
	logic               fold;

	// The user request as a slot where both halves may be set at once
	assign new_slot = '{
		write: avl_write,
		waddr: avl_waddr,
		wdata: avl_wdata,
		read:  avl_read,
		raddr: avl_raddr
	};

	// Requests are taken only while the queue has room
	assign avl_ready = ~full;
	assign accept    = avl_ready & (avl_write | avl_read);

	// A lone write joins a held read-only slot so one QDR cycle carries both
	// The read half then sees the memory contents from before this write
	// which keeps the user's request order intact
	assign fold = accept & hold_valid & hold_slot.read & ~hold_slot.write &
		avl_write & ~avl_read;

	// The held slot leaves unless it is being completed by a fold
	// While the queue is full it simply waits in the hold register
	assign push      = hold_valid & ~fold & ~full;
	assign push_slot = hold_slot;

	//////////////////////////////////////////////////
	// Hold register

	always_ff @(posedge clk or negedge reset_n)
	begin
		if (!reset_n)
			hold_valid <= 1'b0;
		else if (accept)
			hold_valid <= 1'b1;
		else if (push)
			// An idle cycle flushes the held slot
			hold_valid <= 1'b0;
	end

	// A fold fills in only the write half of the held slot
	always_ff @(posedge clk)
	begin
		if (fold)
		begin
			hold_slot.write <= 1'b1;
			hold_slot.waddr <= avl_waddr;
			hold_slot.wdata <= avl_wdata;
		end
		else if (accept)
			hold_slot <= new_slot;
	end

	// The queue never sees a push while it reports full
	a_push_not_full: assert property (@(posedge clk) disable iff (!reset_n)
		push |-> !full);

	// A held slot always carries at least one request for the memory
	a_hold_not_empty: assert property (@(posedge clk) disable iff (!reset_n)
		hold_valid |-> hold_slot.write || hold_slot.read);

endmodule

//--- test/qdr_mem_model.sv
// Behavioural QDR II SRAM with separate read and write ports and a fixed read latency
module qdr_mem_model (
	input  logic                       clk,
	input  qdr_pkg::qdr_pins_t         cmd,
	output logic [qdr_pkg::DATA_W-1:0] q
);
	timeunit 1ns;
	timeprecision 100ps;

	localparam int unsigned DEPTH = 1 << qdr_pkg::ADDR_W;

	logic [qdr_pkg::DATA_W-1:0]   mem [DEPTH];
	// Read data and its valid flag walk one stage per edge toward q
	logic [qdr_pkg::DATA_W-1:0]   rd_data [qdr_pkg::RD_LATENCY+1];
	logic [qdr_pkg::RD_LATENCY:0] rd_valid;

	// Power-up contents, every address bit shows up in the word
	function automatic logic [qdr_pkg::DATA_W-1:0] preset(input logic [qdr_pkg::ADDR_W-1:0] a);
		return {a[7:0], a} ^ 18'h15A5A;
	endfunction

	initial
	begin
		for (int a = 0; a < DEPTH; a++)
			mem[a] = preset(a[qdr_pkg::ADDR_W-1:0]);
		rd_valid = '0;
	end

	// Both ports are sampled at the same edge
	// A read and a write to one address in one cycle return the old word
	always @(posedge clk)
	begin
		rd_valid   <= {rd_valid[qdr_pkg::RD_LATENCY-1:0], ~cmd.r_n};
		rd_data[0] <= mem[cmd.raddr];
		for (int i = 1; i <= qdr_pkg::RD_LATENCY; i++)
			rd_data[i] <= rd_data[i-1];
		if (!cmd.w_n)
			mem[cmd.waddr] <= cmd.d;
	end

	// Unknown outside the valid window so mistimed captures show up
	assign q = rd_valid[qdr_pkg::RD_LATENCY] ? rd_data[qdr_pkg::RD_LATENCY] : 'x;

endmodule

//--- test/tb_qdr_ctrl.sv
// Directed testbench for the QDR II command path running against a behavioural SRAM
module tb_qdr_ctrl;
	timeunit 1ns;
	timeprecision 100ps;

	typedef logic [qdr_pkg::ADDR_W-1:0] addr_t;
	typedef logic [qdr_pkg::DATA_W-1:0] data_t;

	localparam int TIMEOUT = 200;

	logic               clk = 1'b0;
	logic               reset_n;
	logic               avl_write;
	addr_t              avl_waddr;
	data_t              avl_wdata;
	logic               avl_read;
	addr_t              avl_raddr;
	logic               avl_ready;
	logic               avl_rdata_valid;
	data_t              avl_rdata;
	logic               init_complete;
	logic               init_fail;
	qdr_pkg::qdr_pins_t mem_cmd;
	data_t              mem_q;

	// Expected memory contents and read data still owed by the DUT
	data_t       ref_mem [1 << qdr_pkg::ADDR_W];
	data_t       exp_q [$];
	logic [15:0] lfsr = 16'd31537;
	int          wr_sent = 0;
	int          wr_cmds = 0;
	int          rd_cmds = 0;
	int          rd_pulses = 0;
	string       test_name = "reset";

	always #10 clk = ~clk;

	qdr_ctrl_top i_dut (
		.clk             (clk),
		.reset_n         (reset_n),
		.avl_write       (avl_write),
		.avl_waddr       (avl_waddr),
		.avl_wdata       (avl_wdata),
		.avl_read        (avl_read),
		.avl_raddr       (avl_raddr),
		.avl_ready       (avl_ready),
		.avl_rdata_valid (avl_rdata_valid),
		.avl_rdata       (avl_rdata),
		.init_complete   (init_complete),
		.init_fail       (init_fail),
		.mem_cmd         (mem_cmd),
		.mem_q           (mem_q)
	);

	qdr_mem_model i_mem (
		.clk (clk),
		.cmd (mem_cmd),
		.q   (mem_q)
	);

	//////////////////////////////////////////////////
	// Reporting and checks

	task automatic abort_run();
		$display("Simulation finished: FAIL");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_data(input string name, input data_t expected, input data_t actual);
		if (actual !== expected)
		begin
			$display("[FAIL] %s: expected %h, actual %h", name, expected, actual);
			abort_run();
		end
	endtask

	task automatic check_count(input string name, input integer expected, input integer actual);
		if (actual !== expected)
		begin
			$display("[FAIL] %s: expected %0d, actual %0d", name, expected, actual);
			abort_run();
		end
	endtask

	//////////////////////////////////////////////////
	// Stimulus helpers

	// Taps of x^16 + x^14 + x^13 + x^11 + 1 with one step per bit handed out
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] bits;
		logic        fb;
		bits = '0;
		for (int i = 0; i < n; i++)
		begin
			fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
			lfsr = {lfsr[14:0], fb};
			bits = {bits[30:0], fb};
		end
		return bits;
	endfunction

	function automatic addr_t rand_addr();
		return addr_t'(rand_bits(qdr_pkg::ADDR_W));
	endfunction

	function automatic data_t rand_data();
		return data_t'(rand_bits(qdr_pkg::DATA_W));
	endfunction

	function automatic logic rand_flag();
		logic [31:0] b;
		b = rand_bits(1);
		return b[0];
	endfunction

	task automatic idle();
		avl_write <= 1'b0;
		avl_read  <= 1'b0;
	endtask

	// Holds one request until an edge takes it with avl_ready high
	// Within one request the read sees the memory before the write
	task automatic send(input logic wr, input addr_t waddr, input data_t wdata,
		input logic rd, input addr_t raddr);
		int   cycles;
		logic taken;
		cycles = 0;
		taken  = 1'b0;
		avl_write <= wr;
		avl_waddr <= waddr;
		avl_wdata <= wdata;
		avl_read  <= rd;
		avl_raddr <= raddr;
		while (!taken)
		begin
			@(negedge clk);
			taken = avl_ready;
			@(posedge clk);
			cycles++;
			if (!taken && cycles >= TIMEOUT)
			begin
				$display("Request in test %s was never accepted", test_name);
				abort_run();
			end
		end
		if (rd)
			exp_q.push_back(ref_mem[raddr]);
		if (wr)
		begin
			ref_mem[waddr] = wdata;
			wr_sent++;
		end
	endtask

	// Waits until every accepted write hit the pins and every read came back
	task automatic drain();
		int cycles;
		cycles = 0;
		while (exp_q.size() != 0 || wr_cmds < wr_sent)
		begin
			@(posedge clk);
			cycles++;
			if (cycles >= TIMEOUT)
			begin
				$display("Commands of test %s did not complete in time", test_name);
				abort_run();
			end
		end
	endtask

	task automatic apply_reset();
		reset_n       <= 1'b0;
		init_complete <= 1'b0;
		init_fail     <= 1'b0;
		idle();
		repeat (8) @(posedge clk);
		reset_n <= 1'b1;
		@(posedge clk);
	endtask

	//////////////////////////////////////////////////
	// Response monitor

	always @(negedge clk)
	begin
		if (reset_n)
		begin
			if (!mem_cmd.w_n)
				wr_cmds++;
			if (!mem_cmd.r_n)
				rd_cmds++;
			if (avl_rdata_valid)
			begin
				rd_pulses++;
				if (exp_q.size() == 0)
				begin
					$display("Read data returned in test %s with no read pending", test_name);
					abort_run();
				end
				else
					check_data(test_name, exp_q.pop_front(), avl_rdata);
			end
		end
	end

	//////////////////////////////////////////////////
	// Tests

	task automatic test_gating();
		addr_t a [qdr_pkg::FIFO_DEPTH+1];
		test_name = "gating";
		@(negedge clk);
		check_count("gating ready after reset", 1, int'(avl_ready));
		@(posedge clk);
		// Eight slots fill the queue and one more waits in the hold register
		for (int i = 0; i <= qdr_pkg::FIFO_DEPTH; i++)
		begin
			a[i] = rand_addr();
			send(1'b1, a[i], rand_data(), 1'b0, '0);
		end
		idle();
		repeat (20)
		begin
			@(negedge clk);
			check_count("gating ready while full", 0, int'(avl_ready));
		end
		check_count("gating writes before init", 0, wr_cmds);
		check_count("gating reads before init", 0, rd_cmds);
		@(posedge clk);
		init_complete <= 1'b1;
		for (int i = 0; i <= qdr_pkg::FIFO_DEPTH; i++)
			send(1'b0, '0, '0, 1'b1, a[i]);
		idle();
		drain();
		check_count("gating writes landed", qdr_pkg::FIFO_DEPTH + 1, wr_cmds);
	endtask

	task automatic test_write_read();
		addr_t a [16];
		test_name = "write_read";
		for (int i = 0; i < 16; i++)
		begin
			a[i] = rand_addr();
			send(1'b1, a[i], rand_data(), 1'b0, '0);
		end
		for (int i = 0; i < 16; i++)
			send(1'b0, '0, '0, 1'b1, a[i]);
		idle();
		drain();
	endtask

	task automatic test_simultaneous();
		addr_t wa;
		test_name = "simultaneous";
		wa = rand_addr();
		send(1'b1, wa, rand_data(), 1'b1, ~wa);
		send(1'b0, '0, '0, 1'b1, wa);
		idle();
		drain();
	endtask

	task automatic test_read_before_write();
		addr_t a;
		test_name = "read_before_write";
		a = rand_addr();
		// The write folds into the held read and must not overtake it
		send(1'b0, '0, '0, 1'b1, a);
		send(1'b1, a, rand_data(), 1'b0, '0);
		send(1'b0, '0, '0, 1'b1, a);
		idle();
		drain();
	endtask

	task automatic test_stream();
		int   reads_sent;
		int   pulses_before;
		logic wr;
		logic rd;
		test_name     = "stream";
		reads_sent    = 0;
		pulses_before = rd_pulses;
		for (int i = 0; i < 48; i++)
		begin
			wr = rand_flag();
			rd = rand_flag() | ~wr;
			send(wr, rand_addr(), rand_data(), rd, rand_addr());
			if (rd)
				reads_sent++;
		end
		idle();
		drain();
		check_count("stream read pulses", reads_sent, rd_pulses - pulses_before);
	endtask

	task automatic test_cal_fail();
		int wr_before;
		int rd_before;
		test_name = "cal_fail";
		apply_reset();
		init_fail <= 1'b1;
		wr_before = wr_cmds;
		rd_before = rd_cmds;
		// Requests are offered every cycle and nothing may reach the pins
		// Any read data pulse is caught by the monitor
		for (int i = 0; i < 30; i++)
		begin
			avl_write <= 1'b1;
			avl_waddr <= rand_addr();
			avl_wdata <= rand_data();
			avl_read  <= 1'b1;
			avl_raddr <= rand_addr();
			@(posedge clk);
		end
		idle();
		repeat (20)
		begin
			@(negedge clk);
			check_count("cal_fail ready", 0, int'(avl_ready));
		end
		check_count("cal_fail writes", wr_before, wr_cmds);
		check_count("cal_fail reads", rd_before, rd_cmds);
	endtask

	initial
	begin
		reset_n       = 1'b0;
		avl_write     = 1'b0;
		avl_waddr     = '0;
		avl_wdata     = '0;
		avl_read      = 1'b0;
		avl_raddr     = '0;
		init_complete = 1'b0;
		init_fail     = 1'b0;
		// Same power-up pattern as the memory model
		for (int a = 0; a < (1 << qdr_pkg::ADDR_W); a++)
			ref_mem[a] = {a[7:0], a[qdr_pkg::ADDR_W-1:0]} ^ 18'h15A5A;
		apply_reset();
		test_gating();
		test_write_read();
		test_simultaneous();
		test_read_before_write();
		test_stream();
		test_cal_fail();
		$display("Simulation finished: PASS");
		$finish;
	end

endmodule
